// ==== cl_hello_world_pkg.sv ====
package cl_hello_world_pkg;

  // --------------------
  // Bus and field widths
  // --------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int LED_W  = 16;
  localparam int CNT_W  = 16;
  localparam int TICK_W = 8;

  // --------------------
  // OCL register map
  // --------------------
  typedef enum logic [ADDR_W-1:0] {
    HELLO_WORLD_ADDR = 32'h0000_0500,
    VLED_ADDR        = 32'h0000_0504,
    CNT_CTRL_ADDR    = 32'h0000_0508,
    CNT_LOAD_ADDR    = 32'h0000_050C,
    CNT_WMARK_ADDR   = 32'h0000_0510,
    CNT_STATUS_ADDR  = 32'h0000_0514
  } reg_addr_e;

  // Counter control fields
  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_CLEAR_BIT   = 1;
  localparam int CTRL_ONESHOT_BIT = 2;
  localparam int CTRL_TICK_LSB    = 8;

  // AXI response code
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Channel state machines
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_RESP} rd_state_e;

endpackage

// ==== ocl_slave.sv ====
module ocl_slave
  import cl_hello_world_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  // OCL AXI-Lite from the shell
  input  logic              sh_ocl_awvalid,
  input  logic [ADDR_W-1:0] sh_ocl_awaddr,
  input  logic              sh_ocl_wvalid,
  input  logic [DATA_W-1:0] sh_ocl_wdata,
  input  logic              sh_ocl_bready,
  input  logic              sh_ocl_arvalid,
  input  logic [ADDR_W-1:0] sh_ocl_araddr,
  input  logic              sh_ocl_rready,
  output logic              ocl_sh_awready,
  output logic              ocl_sh_wready,
  output logic              ocl_sh_bvalid,
  output logic [1:0]        ocl_sh_bresp,
  output logic              ocl_sh_arready,
  output logic              ocl_sh_rvalid,
  output logic [DATA_W-1:0] ocl_sh_rdata,
  output logic [1:0]        ocl_sh_rresp,
  // Register file side
  output logic              reg_wr_en,
  output logic [ADDR_W-1:0] reg_wr_addr,
  output logic [DATA_W-1:0] reg_wr_data,
  output logic [ADDR_W-1:0] reg_rd_addr,
  input  logic [DATA_W-1:0] reg_rd_data
);

  wr_state_e         wr_state;
  rd_state_e         rd_state;
  logic [ADDR_W-1:0] wr_addr_q;
  logic [ADDR_W-1:0] rd_addr_q;
  logic [DATA_W-1:0] rdata_q;

  // --------------------
  // Write channel
  // --------------------
  // Single beat only, AW first then W
  assign ocl_sh_awready = (wr_state == WR_IDLE);
  assign ocl_sh_wready  = (wr_state == WR_DATA) && sh_ocl_wvalid;
  assign ocl_sh_bvalid  = (wr_state == WR_RESP);
  assign ocl_sh_bresp   = RESP_OKAY;

  // Register strobe fires on the W beat itself
  assign reg_wr_en   = ocl_sh_wready;
  assign reg_wr_addr = wr_addr_q;
  assign reg_wr_data = sh_ocl_wdata;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_state <= WR_IDLE;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
        begin
          if (sh_ocl_awvalid)
          begin
            wr_state <= WR_DATA;
          end
        end
        WR_DATA:
        begin
          if (sh_ocl_wvalid)
          begin
            wr_state <= WR_RESP;
          end
        end
        WR_RESP:
        begin
          // Hold bvalid until the shell takes it
          if (sh_ocl_bready)
          begin
            wr_state <= WR_IDLE;
          end
        end
        default:
        begin
          wr_state <= WR_IDLE;
        end
      endcase
    end
  end

  // Write address capture on AW handshake
  always_ff @(posedge clk_main_a0)
  begin
    if (ocl_sh_awready && sh_ocl_awvalid)
    begin
      wr_addr_q <= sh_ocl_awaddr;
    end
  end

  // --------------------
  // Read channel
  // --------------------
  assign ocl_sh_arready = (rd_state == RD_IDLE);
  assign ocl_sh_rvalid  = (rd_state == RD_RESP);
  assign ocl_sh_rdata   = rdata_q;
  assign ocl_sh_rresp   = RESP_OKAY;
  assign reg_rd_addr    = rd_addr_q;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rd_state <= RD_IDLE;
      rdata_q  <= '0;
    end
    else
    begin
      case (rd_state)
        RD_IDLE:
        begin
          if (sh_ocl_arvalid)
          begin
            rd_state <= RD_ADDR;
          end
        end
        RD_ADDR:
        begin
          // Mux output settles during this cycle, capture it
          rdata_q  <= reg_rd_data;
          rd_state <= RD_RESP;
        end
        RD_RESP:
        begin
          if (sh_ocl_rready)
          begin
            rd_state <= RD_IDLE;
          end
        end
        default:
        begin
          rd_state <= RD_IDLE;
        end
      endcase
    end
  end

  // Read address capture on AR handshake
  always_ff @(posedge clk_main_a0)
  begin
    if (ocl_sh_arready && sh_ocl_arvalid)
    begin
      rd_addr_q <= sh_ocl_araddr;
    end
  end

endmodule

// ==== hello_regs.sv ====
module hello_regs
  import cl_hello_world_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              reg_wr_en,
  input  logic [ADDR_W-1:0] reg_wr_addr,
  input  logic [DATA_W-1:0] reg_wr_data,
  input  logic [ADDR_W-1:0] reg_rd_addr,
  output logic [DATA_W-1:0] reg_rd_data,
  output logic [LED_W-1:0]  hello_low,
  input  logic [LED_W-1:0]  vled_shadow,
  output logic              cnt_enable,
  output logic              cnt_clear,
  output logic              cnt_oneshot,
  output logic [TICK_W-1:0] tick_value,
  output logic              cnt_load,
  output logic [CNT_W-1:0]  cnt_load_value,
  output logic [CNT_W-1:0]  cnt_watermark,
  input  logic [CNT_W-1:0]  cnt_value,
  input  logic              cnt_ge_watermark
);

  logic [DATA_W-1:0] hello_world_q;
  logic [DATA_W-1:0] hello_swapped;
  logic [DATA_W-1:0] ctrl_rd;

  // --------------------
  // Write decode
  // --------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      hello_world_q  <= '0;
      cnt_enable     <= 1'b0;
      cnt_clear      <= 1'b0;
      cnt_oneshot    <= 1'b0;
      tick_value     <= '0;
      cnt_load_value <= '0;
      cnt_watermark  <= '0;
      cnt_load       <= 1'b0;
    end
    else
    begin
      // Load strobe lasts one cycle, value lands on the same edge
      cnt_load <= reg_wr_en && (reg_wr_addr == CNT_LOAD_ADDR);
      if (reg_wr_en)
      begin
        case (reg_wr_addr)
          HELLO_WORLD_ADDR: hello_world_q <= reg_wr_data;
          CNT_CTRL_ADDR:
          begin
            cnt_enable  <= reg_wr_data[CTRL_ENABLE_BIT];
            cnt_clear   <= reg_wr_data[CTRL_CLEAR_BIT];
            cnt_oneshot <= reg_wr_data[CTRL_ONESHOT_BIT];
            tick_value  <= reg_wr_data[CTRL_TICK_LSB +: TICK_W];
          end
          CNT_LOAD_ADDR:  cnt_load_value <= reg_wr_data[CNT_W-1:0];
          CNT_WMARK_ADDR: cnt_watermark  <= reg_wr_data[CNT_W-1:0];
          // VLED and status are read-only
          default:
          begin
          end
        endcase
      end
    end
  end

  // LED shadow source
  assign hello_low = hello_world_q[LED_W-1:0];

  // Hello-world reads back byte-reversed
  assign hello_swapped = {hello_world_q[7:0], hello_world_q[15:8],
                          hello_world_q[23:16], hello_world_q[31:24]};

  // Control word as written, unused bits zero
  always_comb
  begin
    ctrl_rd                               = '0;
    ctrl_rd[CTRL_ENABLE_BIT]              = cnt_enable;
    ctrl_rd[CTRL_CLEAR_BIT]               = cnt_clear;
    ctrl_rd[CTRL_ONESHOT_BIT]             = cnt_oneshot;
    ctrl_rd[CTRL_TICK_LSB +: TICK_W]      = tick_value;
  end

  // --------------------
  // Read mux
  // --------------------
  always_comb
  begin
    case (reg_rd_addr)
      HELLO_WORLD_ADDR: reg_rd_data = hello_swapped;
      VLED_ADDR:        reg_rd_data = {{(DATA_W-LED_W){1'b0}}, vled_shadow};
      CNT_CTRL_ADDR:    reg_rd_data = ctrl_rd;
      CNT_LOAD_ADDR:    reg_rd_data = {{(DATA_W-CNT_W){1'b0}}, cnt_load_value};
      CNT_WMARK_ADDR:   reg_rd_data = {{(DATA_W-CNT_W){1'b0}}, cnt_watermark};
      // Count low, watermark flag just above it
      CNT_STATUS_ADDR:  reg_rd_data = {{(DATA_W-CNT_W-1){1'b0}}, cnt_ge_watermark, cnt_value};
      // Unmapped space reads zero
      default:          reg_rd_data = '0;
    endcase
  end

endmodule

// ==== vled_status.sv ====
module vled_status
  import cl_hello_world_pkg::*;
(
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic [LED_W-1:0] hello_low,
  input  logic [LED_W-1:0] sh_cl_status_vdip,
  output logic [LED_W-1:0] vled_shadow,
  output logic [LED_W-1:0] cl_sh_status_vled
);

  logic [LED_W-1:0] vdip_q1;
  logic [LED_W-1:0] vdip_q2;

  // --------------------
  // DIP sync and LED mask
  // --------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vdip_q1           <= '0;
      vdip_q2           <= '0;
      vled_shadow       <= '0;
      cl_sh_status_vled <= '0;
    end
    else
    begin
      // Two-flop sync for the shell DIPs
      vdip_q1           <= sh_cl_status_vdip;
      vdip_q2           <= vdip_q1;
      // Shadow follows hello-world low half
      vled_shadow       <= hello_low;
      // LED lit only where its DIP is on
      cl_sh_status_vled <= vled_shadow & vdip_q2;
    end
  end

endmodule

// ==== tick_counter.sv ====
module tick_counter
  import cl_hello_world_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              cnt_enable,
  input  logic              cnt_clear,
  input  logic              cnt_oneshot,
  input  logic [TICK_W-1:0] tick_value,
  input  logic              cnt_load,
  input  logic [CNT_W-1:0]  cnt_load_value,
  input  logic [CNT_W-1:0]  cnt_watermark,
  output logic [CNT_W-1:0]  cnt_value,
  output logic              cnt_ge_watermark
);

  logic [TICK_W-1:0] tick_cnt;
  logic              tick_wrap;
  logic              cnt_sat;
  logic [CNT_W-1:0]  cnt_next;

  // Prescaler reached its terminal value this cycle
  assign tick_wrap = (tick_cnt >= tick_value);

  // One-shot parks at all ones
  assign cnt_sat = cnt_oneshot && (cnt_value == {CNT_W{1'b1}});

  // --------------------
  // Next count
  // --------------------
  // Clear wins over load, load over enable
  always_comb
  begin
    if (cnt_clear)
      cnt_next = '0;
    else if (cnt_load)
      cnt_next = cnt_load_value;
    else if (cnt_enable && tick_wrap && !cnt_sat)
      cnt_next = cnt_value + 1'b1;
    else
      cnt_next = cnt_value;
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      tick_cnt         <= '0;
      cnt_value        <= '0;
      cnt_ge_watermark <= 1'b0;
    end
    else
    begin
      // Prescaler runs 0..tick_value while enabled
      if (cnt_clear)
        tick_cnt <= '0;
      else if (cnt_enable)
        tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
      cnt_value        <= cnt_next;
      // Flag tracks the same count it is stored with
      cnt_ge_watermark <= (cnt_next >= cnt_watermark);
    end
  end

endmodule

// ==== cl_hello_world.sv ====
module cl_hello_world
  import cl_hello_world_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              sh_ocl_awvalid,
  input  logic [ADDR_W-1:0] sh_ocl_awaddr,
  input  logic              sh_ocl_wvalid,
  input  logic [DATA_W-1:0] sh_ocl_wdata,
  input  logic [3:0]        sh_ocl_wstrb,
  input  logic              sh_ocl_bready,
  input  logic              sh_ocl_arvalid,
  input  logic [ADDR_W-1:0] sh_ocl_araddr,
  input  logic              sh_ocl_rready,
  output logic              ocl_sh_awready,
  output logic              ocl_sh_wready,
  output logic              ocl_sh_bvalid,
  output logic [1:0]        ocl_sh_bresp,
  output logic              ocl_sh_arready,
  output logic              ocl_sh_rvalid,
  output logic [DATA_W-1:0] ocl_sh_rdata,
  output logic [1:0]        ocl_sh_rresp,
  input  logic [LED_W-1:0]  sh_cl_status_vdip,
  output logic [LED_W-1:0]  cl_sh_status_vled
);

  // --------------------
  // Internal nets
  // --------------------
  logic              reg_wr_en;
  logic [ADDR_W-1:0] reg_wr_addr;
  logic [DATA_W-1:0] reg_wr_data;
  logic [ADDR_W-1:0] reg_rd_addr;
  logic [DATA_W-1:0] reg_rd_data;
  logic [LED_W-1:0]  hello_low;
  logic [LED_W-1:0]  vled_shadow;
  logic              cnt_enable;
  logic              cnt_clear;
  logic              cnt_oneshot;
  logic [TICK_W-1:0] tick_value;
  logic              cnt_load;
  logic [CNT_W-1:0]  cnt_load_value;
  logic [CNT_W-1:0]  cnt_watermark;
  logic [CNT_W-1:0]  cnt_value;
  logic              cnt_ge_watermark;

  // Full-word writes only, wstrb stops here
  ocl_slave u_ocl_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .sh_ocl_awvalid  (sh_ocl_awvalid),
    .sh_ocl_awaddr   (sh_ocl_awaddr),
    .sh_ocl_wvalid   (sh_ocl_wvalid),
    .sh_ocl_wdata    (sh_ocl_wdata),
    .sh_ocl_bready   (sh_ocl_bready),
    .sh_ocl_arvalid  (sh_ocl_arvalid),
    .sh_ocl_araddr   (sh_ocl_araddr),
    .sh_ocl_rready   (sh_ocl_rready),
    .ocl_sh_awready  (ocl_sh_awready),
    .ocl_sh_wready   (ocl_sh_wready),
    .ocl_sh_bvalid   (ocl_sh_bvalid),
    .ocl_sh_bresp    (ocl_sh_bresp),
    .ocl_sh_arready  (ocl_sh_arready),
    .ocl_sh_rvalid   (ocl_sh_rvalid),
    .ocl_sh_rdata    (ocl_sh_rdata),
    .ocl_sh_rresp    (ocl_sh_rresp),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .reg_rd_addr     (reg_rd_addr),
    .reg_rd_data     (reg_rd_data)
  );

  hello_regs u_hello_regs (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .reg_wr_en        (reg_wr_en),
    .reg_wr_addr      (reg_wr_addr),
    .reg_wr_data      (reg_wr_data),
    .reg_rd_addr      (reg_rd_addr),
    .reg_rd_data      (reg_rd_data),
    .hello_low        (hello_low),
    .vled_shadow      (vled_shadow),
    .cnt_enable       (cnt_enable),
    .cnt_clear        (cnt_clear),
    .cnt_oneshot      (cnt_oneshot),
    .tick_value       (tick_value),
    .cnt_load         (cnt_load),
    .cnt_load_value   (cnt_load_value),
    .cnt_watermark    (cnt_watermark),
    .cnt_value        (cnt_value),
    .cnt_ge_watermark (cnt_ge_watermark)
  );

  vled_status u_vled_status (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .hello_low         (hello_low),
    .sh_cl_status_vdip (sh_cl_status_vdip),
    .vled_shadow       (vled_shadow),
    .cl_sh_status_vled (cl_sh_status_vled)
  );

  tick_counter u_tick_counter (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .cnt_enable       (cnt_enable),
    .cnt_clear        (cnt_clear),
    .cnt_oneshot      (cnt_oneshot),
    .tick_value       (tick_value),
    .cnt_load         (cnt_load),
    .cnt_load_value   (cnt_load_value),
    .cnt_watermark    (cnt_watermark),
    .cnt_value        (cnt_value),
    .cnt_ge_watermark (cnt_ge_watermark)
  );

endmodule

// ==== cl_hello_world_props.sv ====
module cl_hello_world_props
  import cl_hello_world_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              sh_ocl_awvalid,
  input  logic              ocl_sh_awready,
  input  logic              ocl_sh_bvalid,
  input  logic              sh_ocl_bready,
  input  logic [1:0]        ocl_sh_bresp,
  input  logic              ocl_sh_rvalid,
  input  logic              sh_ocl_rready,
  input  logic [DATA_W-1:0] ocl_sh_rdata,
  input  logic [1:0]        ocl_sh_rresp
);

  // Firing count, read back by the testbench at the end
  int fail_count = 0;

  // --------------------
  // Write channel
  // --------------------
  // AW acceptance leaves the slave busy
  awready_busy_low: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (sh_ocl_awvalid && ocl_sh_awready) |=> !ocl_sh_awready)
  else
  begin
    fail_count++;
    $error("awready still high after an accepted write address");
  end

  // Response parked until the shell takes it
  bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (ocl_sh_bvalid && !sh_ocl_bready) |=> ocl_sh_bvalid)
  else
  begin
    fail_count++;
    $error("bvalid dropped before bready");
  end

  // --------------------
  // Read channel
  // --------------------
  rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (ocl_sh_rvalid && !sh_ocl_rready) |=> (ocl_sh_rvalid && $stable(ocl_sh_rdata)))
  else
  begin
    fail_count++;
    $error("rvalid or rdata changed before rready");
  end

  // Slave never signals an error
  resp_okay: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (!ocl_sh_bvalid || ocl_sh_bresp == RESP_OKAY) &&
    (!ocl_sh_rvalid || ocl_sh_rresp == RESP_OKAY))
  else
  begin
    fail_count++;
    $error("response code not OKAY");
  end

endmodule

// Attach to every OCL slave
bind ocl_slave cl_hello_world_props u_props (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .sh_ocl_awvalid  (sh_ocl_awvalid),
  .ocl_sh_awready  (ocl_sh_awready),
  .ocl_sh_bvalid   (ocl_sh_bvalid),
  .sh_ocl_bready   (sh_ocl_bready),
  .ocl_sh_bresp    (ocl_sh_bresp),
  .ocl_sh_rvalid   (ocl_sh_rvalid),
  .sh_ocl_rready   (sh_ocl_rready),
  .ocl_sh_rdata    (ocl_sh_rdata),
  .ocl_sh_rresp    (ocl_sh_rresp)
);

// ==== cl_hello_world_checker.sv ====
module cl_hello_world_checker
  import cl_hello_world_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              ocl_sh_awready,
  input  logic              ocl_sh_wready,
  input  logic              ocl_sh_arready,
  input  logic              ocl_sh_bvalid,
  input  logic              sh_ocl_bready,
  input  logic [1:0]        ocl_sh_bresp,
  input  logic              ocl_sh_rvalid,
  input  logic              sh_ocl_rready,
  input  logic [DATA_W-1:0] ocl_sh_rdata,
  input  logic [1:0]        ocl_sh_rresp,
  input  logic [LED_W-1:0]  cl_sh_status_vled,
  input  logic              led_check,
  input  int                cur_row,
  input  logic [DATA_W-1:0] cur_exp,
  input  logic              report,
  output int                test_count,
  output int                error_count
);

  int tests_run = 0;
  int tests_bad = 0;
  int errs;

  assign test_count  = tests_run;
  assign error_count = tests_bad;

  // One field against its expected value, 1 on mismatch
  function automatic int compare(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    if (exp_val !== act_val)
    begin
      $display("Fail at time %0t: %s expected 0x%08h, got 0x%08h",
               $time, name, exp_val, act_val);
      return 1;
    end
    return 0;
  endfunction

  // Per-test result line
  task automatic close_test(input string what, input int n_err);
    tests_run++;
    if (n_err == 0)
      $display("Row %0d %s: ok", cur_row, what);
    else
    begin
      tests_bad++;
      $display("Row %0d %s: %0d mismatch(es)", cur_row, what, n_err);
    end
  endtask

  // --------------------
  // Response watch
  // --------------------
  always @(posedge clk_main_a0)
  begin
    // B beat taken this edge
    if (rst_main_n_sync && ocl_sh_bvalid && sh_ocl_bready)
    begin
      errs = compare("ocl_sh_bresp", 32'(RESP_OKAY), 32'(ocl_sh_bresp));
      close_test("write response", errs);
    end
    // R beat taken this edge
    if (rst_main_n_sync && ocl_sh_rvalid && sh_ocl_rready)
    begin
      errs = compare("ocl_sh_rdata", cur_exp, ocl_sh_rdata);
      errs += compare("ocl_sh_rresp", 32'(RESP_OKAY), 32'(ocl_sh_rresp));
      close_test("read data", errs);
    end
    // Quiet bus and LED level
    if (rst_main_n_sync && led_check)
    begin
      errs = compare("cl_sh_status_vled", {16'h0, cur_exp[15:0]}, {16'h0, cl_sh_status_vled});
      errs += compare("ocl_sh_bvalid", 32'h0, {31'h0, ocl_sh_bvalid});
      errs += compare("ocl_sh_rvalid", 32'h0, {31'h0, ocl_sh_rvalid});
      errs += compare("ocl_sh_awready", 32'h1, {31'h0, ocl_sh_awready});
      errs += compare("ocl_sh_wready", 32'h0, {31'h0, ocl_sh_wready});
      errs += compare("ocl_sh_arready", 32'h1, {31'h0, ocl_sh_arready});
      close_test("led status", errs);
    end
  end

  always @(posedge report)
    $display("Tests: %0d run, %0d ok, %0d with mismatches", tests_run,
             tests_run - tests_bad, tests_bad);

endmodule

// ==== tb_cl_hello_world.sv ====
module tb_cl_hello_world
  import cl_hello_world_pkg::*;
();

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_IDLE, OP_LED} op_e;

  // One stimulus row, stall doubles as idle length
  typedef struct {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [15:0] vdip;
    int          stall;
    logic [31:0] exp_val;
  } row_t;

  logic              clk_main_a0 = 1'b0;
  logic              rst_main_n_sync;
  logic              sh_ocl_awvalid;
  logic [ADDR_W-1:0] sh_ocl_awaddr;
  logic              sh_ocl_wvalid;
  logic [DATA_W-1:0] sh_ocl_wdata;
  logic [3:0]        sh_ocl_wstrb;
  logic              sh_ocl_bready;
  logic              sh_ocl_arvalid;
  logic [ADDR_W-1:0] sh_ocl_araddr;
  logic              sh_ocl_rready;
  logic              ocl_sh_awready;
  logic              ocl_sh_wready;
  logic              ocl_sh_bvalid;
  logic [1:0]        ocl_sh_bresp;
  logic              ocl_sh_arready;
  logic              ocl_sh_rvalid;
  logic [DATA_W-1:0] ocl_sh_rdata;
  logic [1:0]        ocl_sh_rresp;
  logic [LED_W-1:0]  sh_cl_status_vdip;
  logic [LED_W-1:0]  cl_sh_status_vled;
  logic              led_check;
  logic              report;
  int                cur_row;
  logic [DATA_W-1:0] cur_exp;
  int                test_count;
  int                error_count;
  row_t              rows[$];
  logic [31:0]       lcg_state = 32'h3933_8be0;
  int                expected_tests = 0;
  int                cycle_count = 0;
  int                timeout_cycles = 0;

  cl_hello_world DUT (.*);

  cl_hello_world_checker u_checker (.*);

  always #50 clk_main_a0 = ~clk_main_a0;

  // Budget of 64 cycles per row
  always @(posedge clk_main_a0)
  begin
    cycle_count++;
    if (timeout_cycles > 0 && cycle_count >= timeout_cycles)
    begin
      $display("Timeout: a handshake never completed within %0d cycles", timeout_cycles);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------
  // Reference helpers
  // --------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int stall_count();
    logic [31:0] r;
    r = next_rand();
    return int'(r[12:10]) + 1;
  endfunction

  // Hello-world reads back with byte order reversed
  function automatic logic [31:0] swap_bytes(input logic [31:0] x);
    return {x[7:0], x[15:8], x[23:16], x[31:24]};
  endfunction

  // Status word, count low and at-or-above flag in bit 16
  function automatic logic [31:0] status_word(input logic [15:0] count,
                                              input logic [15:0] wmark);
    return {15'h0, (count >= wmark), count};
  endfunction

  function automatic void add_row(input op_e op, input logic [31:0] addr,
                                  input logic [31:0] data, input logic [15:0] vdip,
                                  input int stall, input logic [31:0] exp_val);
    row_t r;
    r.op      = op;
    r.addr    = addr;
    r.data    = data;
    r.vdip    = vdip;
    r.stall   = stall;
    r.exp_val = exp_val;
    rows.push_back(r);
    if (op != OP_IDLE)
      expected_tests++;
  endfunction

  // --------------------
  // Stimulus table
  // --------------------
  function automatic void build_table();
    logic [31:0] d;
    logic [31:0] r;
    logic [15:0] w;
    logic [15:0] l;
    int          k;
    // Quiet after reset, count 0 already meets watermark 0
    add_row(OP_LED, 32'h0, 32'h0, 16'h0, 0, 32'h0);
    add_row(OP_RD, HELLO_WORLD_ADDR, 32'h0, 16'h0, 0, 32'h0);
    add_row(OP_RD, VLED_ADDR, 32'h0, 16'h0, 0, 32'h0);
    add_row(OP_RD, CNT_STATUS_ADDR, 32'h0, 16'h0, 0, status_word(16'h0, 16'h0));
    for (k = 0; k < 4; k++)
    begin
      d = next_rand();
      add_row(OP_WR, HELLO_WORLD_ADDR, d, 16'h0, 0, 32'h0);
      add_row(OP_RD, HELLO_WORLD_ADDR, 32'h0, 16'h0, 0, swap_bytes(d));
    end
    // LED is low half masked by DIPs, VLED read unmasked
    for (k = 0; k < 2; k++)
    begin
      d = next_rand();
      r = next_rand();
      add_row(OP_WR, HELLO_WORLD_ADDR, d, r[15:0], 0, 32'h0);
      add_row(OP_IDLE, 32'h0, 32'h0, r[15:0], 4, 32'h0);
      add_row(OP_LED, 32'h0, 32'h0, r[15:0], 0, {16'h0, d[15:0] & r[15:0]});
      add_row(OP_RD, VLED_ADDR, 32'h0, r[15:0], 0, {16'h0, d[15:0]});
    end
    // Load and clear with the counter stopped
    r = next_rand();
    w = r[15:0];
    l = r[31:16];
    for (k = 0; k < 2; k++)
    begin
      add_row(OP_WR, CNT_WMARK_ADDR, {16'h0, w}, 16'hFFFF, 0, 32'h0);
      add_row(OP_WR, CNT_LOAD_ADDR, {16'h0, l}, 16'hFFFF, 0, 32'h0);
      add_row(OP_RD, CNT_STATUS_ADDR, 32'h0, 16'hFFFF, 0, status_word(l, w));
      add_row(OP_RD, CNT_LOAD_ADDR, 32'h0, 16'hFFFF, 0, {16'h0, l});
      add_row(OP_WR, CNT_CTRL_ADDR, 32'h0000_0002, 16'hFFFF, 0, 32'h0);
      add_row(OP_RD, CNT_STATUS_ADDR, 32'h0, 16'hFFFF, 0, status_word(16'h0, w));
      add_row(OP_WR, CNT_CTRL_ADDR, 32'h0, 16'hFFFF, 0, 32'h0);
      // Swap roles so the flag takes both values
      r[15:0] = w;
      w       = l;
      l       = r[15:0];
    end
    // One-shot from FFF0 with tick value 0, parks at FFFF
    add_row(OP_WR, CNT_WMARK_ADDR, 32'h0, 16'hFFFF, 0, 32'h0);
    add_row(OP_WR, CNT_LOAD_ADDR, 32'h0000_FFF0, 16'hFFFF, 0, 32'h0);
    add_row(OP_WR, CNT_CTRL_ADDR, 32'h0000_0005, 16'hFFFF, 0, 32'h0);
    add_row(OP_RD, CNT_CTRL_ADDR, 32'h0, 16'hFFFF, 0, 32'h0000_0005);
    add_row(OP_IDLE, 32'h0, 32'h0, 16'hFFFF, 40, 32'h0);
    add_row(OP_RD, CNT_STATUS_ADDR, 32'h0, 16'hFFFF, 0, status_word(16'hFFFF, 16'h0));
    add_row(OP_IDLE, 32'h0, 32'h0, 16'hFFFF, 8, 32'h0);
    add_row(OP_RD, CNT_STATUS_ADDR, 32'h0, 16'hFFFF, 0, status_word(16'hFFFF, 16'h0));
    // Stalled responses, then unmapped space
    for (k = 0; k < 3; k++)
    begin
      d = next_rand();
      add_row(OP_WR, HELLO_WORLD_ADDR, d, 16'hFFFF, stall_count(), 32'h0);
      add_row(OP_RD, HELLO_WORLD_ADDR, 32'h0, 16'hFFFF, stall_count(), swap_bytes(d));
    end
    add_row(OP_RD, 32'h0000_0600, 32'h0, 16'hFFFF, stall_count(), 32'h0);
    add_row(OP_RD, CNT_WMARK_ADDR, 32'h0, 16'hFFFF, stall_count(), 32'h0);
  endfunction

  // --------------------
  // OCL driver tasks
  // --------------------
  // AW and W together, bready held off for stall cycles
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data, input int stall);
    @(negedge clk_main_a0);
    sh_ocl_awvalid = 1'b1;
    sh_ocl_awaddr  = addr;
    sh_ocl_wvalid  = 1'b1;
    sh_ocl_wdata   = data;
    @(posedge clk_main_a0);
    while (!ocl_sh_awready)
      @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    sh_ocl_awvalid = 1'b0;
    @(posedge clk_main_a0);
    while (!ocl_sh_wready)
      @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    sh_ocl_wvalid = 1'b0;
    repeat (stall) @(negedge clk_main_a0);
    sh_ocl_bready = 1'b1;
    @(posedge clk_main_a0);
    while (!ocl_sh_bvalid)
      @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    sh_ocl_bready = 1'b0;
  endtask

  task automatic read_word(input logic [31:0] addr, input int stall);
    @(negedge clk_main_a0);
    sh_ocl_arvalid = 1'b1;
    sh_ocl_araddr  = addr;
    @(posedge clk_main_a0);
    while (!ocl_sh_arready)
      @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    sh_ocl_arvalid = 1'b0;
    repeat (stall) @(negedge clk_main_a0);
    sh_ocl_rready = 1'b1;
    @(posedge clk_main_a0);
    while (!ocl_sh_rvalid)
      @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    sh_ocl_rready = 1'b0;
  endtask

  // Checker samples the LED on the next rising edge
  task automatic pulse_led_check();
    led_check = 1'b1;
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    led_check = 1'b0;
  endtask

  initial
  begin
    rst_main_n_sync   = 1'b0;
    sh_ocl_awvalid    = 1'b0;
    sh_ocl_awaddr     = '0;
    sh_ocl_wvalid     = 1'b0;
    sh_ocl_wdata      = '0;
    sh_ocl_wstrb      = 4'hF;
    sh_ocl_bready     = 1'b0;
    sh_ocl_arvalid    = 1'b0;
    sh_ocl_araddr     = '0;
    sh_ocl_rready     = 1'b0;
    sh_cl_status_vdip = '0;
    led_check         = 1'b0;
    report            = 1'b0;
    cur_row           = 0;
    cur_exp           = '0;
    build_table();
    timeout_cycles = rows.size() * 64;
    repeat (4) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    foreach (rows[i])
    begin
      cur_row           = i;
      cur_exp           = rows[i].exp_val;
      sh_cl_status_vdip = rows[i].vdip;
      case (rows[i].op)
        OP_WR:   write_word(rows[i].addr, rows[i].data, rows[i].stall);
        OP_RD:   read_word(rows[i].addr, rows[i].stall);
        OP_LED:  pulse_led_check();
        default: repeat (rows[i].stall) @(negedge clk_main_a0);
      endcase
    end
    @(negedge clk_main_a0);
    report = 1'b1;
    @(posedge clk_main_a0);
    if (error_count == 0 && test_count == expected_tests &&
        DUT.u_ocl_slave.u_props.fail_count == 0)
      $display("Test completed successfully");
    else
    begin
      if (test_count != expected_tests)
        $display("Only %0d of %0d tests got a response", test_count, expected_tests);
      if (DUT.u_ocl_slave.u_props.fail_count != 0)
        $display("%0d protocol assertion failures", DUT.u_ocl_slave.u_props.fail_count);
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== cl_hello_world.f ====
cl_hello_world_pkg.sv
ocl_slave.sv
hello_regs.sv
vled_status.sv
tick_counter.sv
cl_hello_world.sv
cl_hello_world_props.sv
cl_hello_world_checker.sv
tb_cl_hello_world.sv

// ==== Makefile ====
# Verilator simulation of the hello-world register block

TOP := tb_cl_hello_world
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cl_hello_world.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) && echo "PASS ($(LOG))" || \
		(echo "FAIL ($(LOG))"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
